// File: Makefile
TOP = tb_exception_manager

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module exception_manager -f build.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: build.f
exc_pkg.sv
exc_sequencer.sv
exc_mem_access.sv
exception_manager.sv
tb_exception_manager.sv

// File: exc_mem_access.sv
/*
  Exception memory-access unit
  Forms IDT and TSS addresses and runs one load/store
  operation at a time against the request/busy/valid port
*/
`timescale 1ns/100ps
`default_nettype none

module exc_mem_access import exc_pkg::*; (
	input  wire                    iCLOCK,
	input  wire                    inRESET,
	// Sequencer side
	input  wire                    op_start,
	input  wire [MEM_OP_W-1:0]     op_kind,
	input  wire [DATA_W-1:0]       snap_idtr,
	input  wire [DATA_W-1:0]       snap_tisr,
	input  wire [TID_W-1:0]        snap_tidr,
	input  wire [DATA_W-1:0]       snap_spr,
	input  wire [IRQ_NUM_W-1:0]    snap_irq_num,
	output logic                   op_done,
	output logic [DATA_W-1:0]      op_rdata,
	// Load/store port
	output logic                   ldst_req,
	output logic                   ldst_rw,
	output logic [DATA_W-1:0]      ldst_addr,
	output logic [DATA_W-1:0]      ldst_wdata,
	input  wire                    ldst_busy,
	input  wire                    ldst_valid,
	input  wire [DATA_W-1:0]       ldst_rdata
);

	logic [MA_W-1:0]     state;
	logic [MEM_OP_W-1:0] kind_q;
	logic [MEM_OP_W-1:0] kind_sel;
	logic [DATA_W-1:0]   tss_base;
	logic [DATA_W-1:0]   idt_addr;

	// Kind is live in the start cycle so the address never moves
	assign kind_sel = op_start ? op_kind : kind_q;

	assign tss_base = snap_tisr +
		({{(DATA_W-TID_W){1'b0}}, snap_tidr} << TSS_SHIFT);
	assign idt_addr = snap_idtr +
		({{(DATA_W-IRQ_NUM_W){1'b0}}, snap_irq_num} << IDT_ENTRY_SHIFT) +
		IDT_VECTOR_OFFSET;

	always_comb begin
		case (kind_sel)
			MEM_USPR_STORE: begin
				ldst_addr = tss_base + TSS_USPR_OFFSET;
				ldst_rw   = 1'b1;
			end
			MEM_KSPR_LOAD: begin
				ldst_addr = tss_base + TSS_KSPR_OFFSET;
				ldst_rw   = 1'b0;
			end
			MEM_KSPR_STORE: begin
				ldst_addr = tss_base + TSS_KSPR_OFFSET;
				ldst_rw   = 1'b1;
			end
			MEM_USPR_LOAD: begin
				ldst_addr = tss_base + TSS_USPR_OFFSET;
				ldst_rw   = 1'b0;
			end
			default: begin
				ldst_addr = idt_addr;
				ldst_rw   = 1'b0;
			end
		endcase
	end

	// Both stores write the current SPR
	assign ldst_wdata = snap_spr;

	assign ldst_req = (state == MA_REQ) && !ldst_busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state   <= MA_WAIT;
			kind_q  <= MEM_VECTOR_READ;
			op_done <= 1'b0;
		end else begin
			op_done <= 1'b0;
			case (state)
				MA_WAIT: begin
					if (op_start) begin
						kind_q <= op_kind;
						state  <= MA_REQ;
					end
				end
				MA_REQ: begin
					if (!ldst_busy) begin
						state <= MA_GET;
					end
				end
				MA_GET: begin
					// Valid closes reads and writes alike
					if (ldst_valid) begin
						op_done <= 1'b1;
						state   <= MA_WAIT;
					end
				end
				default: state <= MA_WAIT;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if ((state == MA_GET) && ldst_valid) begin
			op_rdata <= ldst_rdata;
		end
	end

endmodule

`default_nettype wire

// File: exc_pkg.sv
/*
  Exception manager package
  Field positions, core-mode codes, TSS and IDT layout,
  FSM state codes and memory-operation selectors
*/
`default_nettype none

package exc_pkg;

	// Widths
	localparam int DATA_W    = 32;
	localparam int IRQ_NUM_W = 7;
	localparam int TID_W     = 14;

	// PSR fields
	localparam int PSR_IRQ_EN_BIT = 2;
	localparam int PSR_MODE_LSB   = 5;
	localparam int PSR_MODE_W     = 2;

	localparam logic [PSR_MODE_W-1:0] MODE_KERNEL = 2'b00;
	localparam logic [PSR_MODE_W-1:0] MODE_USER   = 2'b10;

	// Task state segment, 256 bytes per task
	localparam int TSS_SHIFT = 8;
	localparam logic [DATA_W-1:0] TSS_KSPR_OFFSET = 32'd8;
	localparam logic [DATA_W-1:0] TSS_USPR_OFFSET = 32'd12;

	// Interrupt descriptor table, 8 bytes per entry
	localparam int IDT_ENTRY_SHIFT = 3;
	localparam logic [DATA_W-1:0] IDT_VECTOR_OFFSET = 32'd4;

	// Memory operations
	localparam int MEM_OP_W = 3;
	localparam logic [MEM_OP_W-1:0] MEM_VECTOR_READ = 3'd0;
	localparam logic [MEM_OP_W-1:0] MEM_USPR_STORE  = 3'd1;
	localparam logic [MEM_OP_W-1:0] MEM_KSPR_LOAD   = 3'd2;
	localparam logic [MEM_OP_W-1:0] MEM_KSPR_STORE  = 3'd3;
	localparam logic [MEM_OP_W-1:0] MEM_USPR_LOAD   = 3'd4;

	// Main states
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE    = 2'd0;
	localparam logic [ST_W-1:0] ST_JUMP    = 2'd1;
	localparam logic [ST_W-1:0] ST_IRQ_SET = 2'd2;
	localparam logic [ST_W-1:0] ST_IRQ_RET = 2'd3;

	// Entry and return sub-states
	localparam int SUB_W = 3;
	localparam logic [SUB_W-1:0] SUB_SET_VEC_REQ   = 3'd0;
	localparam logic [SUB_W-1:0] SUB_SET_VEC_WAIT  = 3'd1;
	localparam logic [SUB_W-1:0] SUB_SET_USPR_WAIT = 3'd2;
	localparam logic [SUB_W-1:0] SUB_SET_KSPR_WAIT = 3'd3;
	localparam logic [SUB_W-1:0] SUB_RET_CHECK     = 3'd0;
	localparam logic [SUB_W-1:0] SUB_RET_KSPR_WAIT = 3'd1;
	localparam logic [SUB_W-1:0] SUB_RET_USPR_WAIT = 3'd2;

	// Memory-access unit states
	localparam int MA_W = 2;
	localparam logic [MA_W-1:0] MA_WAIT = 2'd0;
	localparam logic [MA_W-1:0] MA_REQ  = 2'd1;
	localparam logic [MA_W-1:0] MA_GET  = 2'd2;

endpackage

`default_nettype wire

// File: exc_sequencer.sv
/*
  Exception sequencer
  Accepts jump, interrupt and interrupt-return events in idle,
  walks the entry and return sequences and drives core control
*/
`timescale 1ns/100ps
`default_nettype none

module exc_sequencer import exc_pkg::*; (
	input  wire                    iCLOCK,
	input  wire                    inRESET,
	// Core events
	input  wire                    except_jump,
	input  wire [DATA_W-1:0]       jump_addr,
	input  wire                    except_ret,
	input  wire                    irq_req,
	input  wire [IRQ_NUM_W-1:0]    irq_num,
	input  wire [DATA_W-1:0]       irq_fi0r,
	input  wire                    interrupt_lock,
	// System registers
	input  wire [DATA_W-1:0]       sysreg_spr,
	input  wire [DATA_W-1:0]       sysreg_tidr,
	input  wire [DATA_W-1:0]       sysreg_tisr,
	input  wire [DATA_W-1:0]       sysreg_psr,
	input  wire [DATA_W-1:0]       sysreg_ppsr,
	input  wire [DATA_W-1:0]       sysreg_pcr,
	input  wire [DATA_W-1:0]       sysreg_ppcr,
	input  wire [DATA_W-1:0]       sysreg_idtr,
	// Memory-access unit
	input  wire                    op_done,
	input  wire [DATA_W-1:0]       op_rdata,
	output logic                   op_start,
	output logic [MEM_OP_W-1:0]    op_kind,
	output logic [DATA_W-1:0]      snap_idtr,
	output logic [DATA_W-1:0]      snap_tisr,
	output logic [TID_W-1:0]       snap_tidr,
	output logic [DATA_W-1:0]      snap_spr,
	output logic [IRQ_NUM_W-1:0]   snap_irq_num,
	// Core control
	output logic                   register_lock,
	output logic                   pipeline_stop,
	output logic                   refresh,
	output logic                   pc_set,
	output logic [DATA_W-1:0]      pc,
	output logic                   ppcr_set,
	output logic [DATA_W-1:0]      ppcr_out,
	output logic                   fi0r_set,
	output logic [DATA_W-1:0]      fi0r,
	output logic                   set_irq_mode,
	output logic                   clr_irq_mode,
	output logic                   cache_flush,
	output logic                   tlb_flush,
	output logic                   spr_write,
	output logic [DATA_W-1:0]      spr_value,
	output logic                   irq_ack
);

	logic [ST_W-1:0]       state;
	logic [SUB_W-1:0]      sub_state;
	logic [PSR_MODE_W-1:0] psr_mode;
	logic [PSR_MODE_W-1:0] ppsr_mode;

	logic irq_cond;
	logic accept;
	logic vec_done;
	logic spr_load_done;

	assign irq_cond = irq_req && !interrupt_lock && sysreg_psr[PSR_IRQ_EN_BIT];
	assign accept   = except_jump || irq_cond || except_ret;

	assign vec_done = op_done && (state == ST_IRQ_SET) && (sub_state == SUB_SET_VEC_WAIT);

	// Final SPR load of either swap sequence
	assign spr_load_done = op_done &&
		(((state == ST_IRQ_SET) && (sub_state == SUB_SET_KSPR_WAIT)) ||
		((state == ST_IRQ_RET) && (sub_state == SUB_RET_USPR_WAIT)));

	// Stall while busy, or when an interrupt is about to be taken
	assign pipeline_stop = (state != ST_IDLE) || (irq_cond && !except_jump);
	assign register_lock = pipeline_stop || refresh || pc_set;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state        <= ST_IDLE;
			sub_state    <= '0;
			op_start     <= 1'b0;
			op_kind      <= MEM_VECTOR_READ;
			refresh      <= 1'b0;
			pc_set       <= 1'b0;
			ppcr_set     <= 1'b0;
			fi0r_set     <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			cache_flush  <= 1'b0;
			tlb_flush    <= 1'b0;
			spr_write    <= 1'b0;
			irq_ack      <= 1'b0;
		end else begin
			// Pulses last one cycle unless set below
			op_start     <= 1'b0;
			refresh      <= 1'b0;
			pc_set       <= 1'b0;
			ppcr_set     <= 1'b0;
			fi0r_set     <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			cache_flush  <= 1'b0;
			tlb_flush    <= 1'b0;
			spr_write    <= 1'b0;
			irq_ack      <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (except_jump) begin
						state   <= ST_JUMP;
						refresh <= 1'b1;
					end else if (irq_cond) begin
						state        <= ST_IRQ_SET;
						sub_state    <= SUB_SET_VEC_REQ;
						refresh      <= 1'b1;
						ppcr_set     <= 1'b1;
						set_irq_mode <= 1'b1;
					end else if (except_ret) begin
						state       <= ST_IRQ_RET;
						sub_state   <= SUB_RET_CHECK;
						refresh     <= 1'b1;
						cache_flush <= 1'b1;
						tlb_flush   <= 1'b1;
					end
				end

				ST_JUMP: begin
					pc_set <= 1'b1;
					state  <= ST_IDLE;
				end

				ST_IRQ_SET: begin
					case (sub_state)
						SUB_SET_VEC_REQ: begin
							op_start  <= 1'b1;
							op_kind   <= MEM_VECTOR_READ;
							sub_state <= SUB_SET_VEC_WAIT;
						end
						SUB_SET_VEC_WAIT: begin
							if (op_done) begin
								if (psr_mode == MODE_KERNEL) begin
									pc_set   <= 1'b1;
									fi0r_set <= 1'b1;
									irq_ack  <= 1'b1;
									state    <= ST_IDLE;
								end else begin
									// Park user SPR in the TSS first
									op_start  <= 1'b1;
									op_kind   <= MEM_USPR_STORE;
									sub_state <= SUB_SET_USPR_WAIT;
								end
							end
						end
						SUB_SET_USPR_WAIT: begin
							if (op_done) begin
								op_start  <= 1'b1;
								op_kind   <= MEM_KSPR_LOAD;
								sub_state <= SUB_SET_KSPR_WAIT;
							end
						end
						SUB_SET_KSPR_WAIT: begin
							if (op_done) begin
								spr_write <= 1'b1;
								pc_set    <= 1'b1;
								fi0r_set  <= 1'b1;
								irq_ack   <= 1'b1;
								state     <= ST_IDLE;
							end
						end
						default: state <= ST_IDLE;
					endcase
				end

				ST_IRQ_RET: begin
					case (sub_state)
						SUB_RET_CHECK: begin
							if (ppsr_mode == MODE_USER) begin
								op_start  <= 1'b1;
								op_kind   <= MEM_KSPR_STORE;
								sub_state <= SUB_RET_KSPR_WAIT;
							end else begin
								pc_set       <= 1'b1;
								clr_irq_mode <= 1'b1;
								state        <= ST_IDLE;
							end
						end
						SUB_RET_KSPR_WAIT: begin
							if (op_done) begin
								op_start  <= 1'b1;
								op_kind   <= MEM_USPR_LOAD;
								sub_state <= SUB_RET_USPR_WAIT;
							end
						end
						SUB_RET_USPR_WAIT: begin
							if (op_done) begin
								spr_write    <= 1'b1;
								pc_set       <= 1'b1;
								clr_irq_mode <= 1'b1;
								state        <= ST_IDLE;
							end
						end
						default: state <= ST_IDLE;
					endcase
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Snapshot and result registers
	always_ff @(posedge iCLOCK) begin
		if ((state == ST_IDLE) && accept) begin
			snap_spr     <= sysreg_spr;
			snap_tidr    <= sysreg_tidr[TID_W-1:0];
			snap_tisr    <= sysreg_tisr;
			snap_idtr    <= sysreg_idtr;
			snap_irq_num <= irq_num;
			psr_mode     <= sysreg_psr[PSR_MODE_LSB +: PSR_MODE_W];
			ppsr_mode    <= sysreg_ppsr[PSR_MODE_LSB +: PSR_MODE_W];
			ppcr_out     <= sysreg_pcr;
			fi0r         <= irq_fi0r;
			// Return target by default, vector replaces it on entry
			pc           <= except_jump ? jump_addr : sysreg_ppcr;
		end
		if (vec_done) begin
			pc <= op_rdata;
		end
		if (spr_load_done) begin
			spr_value <= op_rdata;
		end
	end

endmodule

`default_nettype wire

// File: exception_manager.sv
/*
  Exception manager top level
  Sequencer plus its load/store client
*/
`timescale 1ns/100ps
`default_nettype none

module exception_manager import exc_pkg::*; (
	input  wire                    iCLOCK,
	input  wire                    inRESET,
	// Core events
	input  wire                    except_jump,
	input  wire [DATA_W-1:0]       jump_addr,
	input  wire                    except_ret,
	input  wire                    irq_req,
	input  wire [IRQ_NUM_W-1:0]    irq_num,
	input  wire [DATA_W-1:0]       irq_fi0r,
	input  wire                    interrupt_lock,
	// System registers
	input  wire [DATA_W-1:0]       sysreg_spr,
	input  wire [DATA_W-1:0]       sysreg_tidr,
	input  wire [DATA_W-1:0]       sysreg_tisr,
	input  wire [DATA_W-1:0]       sysreg_psr,
	input  wire [DATA_W-1:0]       sysreg_ppsr,
	input  wire [DATA_W-1:0]       sysreg_pcr,
	input  wire [DATA_W-1:0]       sysreg_ppcr,
	input  wire [DATA_W-1:0]       sysreg_idtr,
	// Core control
	output wire                    register_lock,
	output wire                    pipeline_stop,
	output wire                    refresh,
	output wire                    pc_set,
	output wire [DATA_W-1:0]       pc,
	output wire                    ppcr_set,
	output wire [DATA_W-1:0]       ppcr_out,
	output wire                    fi0r_set,
	output wire [DATA_W-1:0]       fi0r,
	output wire                    set_irq_mode,
	output wire                    clr_irq_mode,
	output wire                    cache_flush,
	output wire                    tlb_flush,
	output wire                    spr_write,
	output wire [DATA_W-1:0]       spr_value,
	output wire                    irq_ack,
	// Load/store port
	output wire                    ldst_req,
	output wire                    ldst_rw,
	output wire [DATA_W-1:0]       ldst_addr,
	output wire [DATA_W-1:0]       ldst_wdata,
	input  wire                    ldst_busy,
	input  wire                    ldst_valid,
	input  wire [DATA_W-1:0]       ldst_rdata
);

	wire                 op_start;
	wire [MEM_OP_W-1:0]  op_kind;
	wire                 op_done;
	wire [DATA_W-1:0]    op_rdata;
	wire [DATA_W-1:0]    snap_idtr;
	wire [DATA_W-1:0]    snap_tisr;
	wire [TID_W-1:0]     snap_tidr;
	wire [DATA_W-1:0]    snap_spr;
	wire [IRQ_NUM_W-1:0] snap_irq_num;

	exc_sequencer u_sequencer (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.except_jump    (except_jump),
		.jump_addr      (jump_addr),
		.except_ret     (except_ret),
		.irq_req        (irq_req),
		.irq_num        (irq_num),
		.irq_fi0r       (irq_fi0r),
		.interrupt_lock (interrupt_lock),
		.sysreg_spr     (sysreg_spr),
		.sysreg_tidr    (sysreg_tidr),
		.sysreg_tisr    (sysreg_tisr),
		.sysreg_psr     (sysreg_psr),
		.sysreg_ppsr    (sysreg_ppsr),
		.sysreg_pcr     (sysreg_pcr),
		.sysreg_ppcr    (sysreg_ppcr),
		.sysreg_idtr    (sysreg_idtr),
		.op_done        (op_done),
		.op_rdata       (op_rdata),
		.op_start       (op_start),
		.op_kind        (op_kind),
		.snap_idtr      (snap_idtr),
		.snap_tisr      (snap_tisr),
		.snap_tidr      (snap_tidr),
		.snap_spr       (snap_spr),
		.snap_irq_num   (snap_irq_num),
		.register_lock  (register_lock),
		.pipeline_stop  (pipeline_stop),
		.refresh        (refresh),
		.pc_set         (pc_set),
		.pc             (pc),
		.ppcr_set       (ppcr_set),
		.ppcr_out       (ppcr_out),
		.fi0r_set       (fi0r_set),
		.fi0r           (fi0r),
		.set_irq_mode   (set_irq_mode),
		.clr_irq_mode   (clr_irq_mode),
		.cache_flush    (cache_flush),
		.tlb_flush      (tlb_flush),
		.spr_write      (spr_write),
		.spr_value      (spr_value),
		.irq_ack        (irq_ack)
	);

	exc_mem_access u_mem_access (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.op_start     (op_start),
		.op_kind      (op_kind),
		.snap_idtr    (snap_idtr),
		.snap_tisr    (snap_tisr),
		.snap_tidr    (snap_tidr),
		.snap_spr     (snap_spr),
		.snap_irq_num (snap_irq_num),
		.op_done      (op_done),
		.op_rdata     (op_rdata),
		.ldst_req     (ldst_req),
		.ldst_rw      (ldst_rw),
		.ldst_addr    (ldst_addr),
		.ldst_wdata   (ldst_wdata),
		.ldst_busy    (ldst_busy),
		.ldst_valid   (ldst_valid),
		.ldst_rdata   (ldst_rdata)
	);

endmodule

`default_nettype wire

// File: tb_exception_manager.sv
/*
  Exception manager testbench
  Runs jumps, interrupt entries and returns against a behavioral
  load/store memory and checks the core-control pulses
*/
`timescale 1ns/100ps
`default_nettype none

module tb_exception_manager import exc_pkg::*; ();

	localparam real CLK_PERIOD      = 4.0;
	localparam real DRIVE_DELAY     = 0.5;
	localparam int  RESET_CYCLES    = 8;
	localparam int  TEST_COUNT      = 6;
	localparam int  CYCLES_PER_TEST = 400;
	localparam int  MARKER_TIMEOUT  = 100;
	localparam logic [31:0] SEED    = 32'h5af74ded;

	localparam int EV_JUMP = 0;
	localparam int EV_IRQ  = 1;
	localparam int EV_RET  = 2;

	// Register contents used by every sequence
	localparam logic [IRQ_NUM_W-1:0] IRQ_NUMBER = 7'd37;
	localparam logic [DATA_W-1:0] IDTR_VAL = 32'h0004_0000;
	localparam logic [DATA_W-1:0] TISR_VAL = 32'h0010_0000;
	localparam logic [DATA_W-1:0] TIDR_VAL = 32'h0000_0123;
	localparam logic [DATA_W-1:0] SPR_VAL  = 32'h7fff_eff0;
	localparam logic [DATA_W-1:0] PCR_VAL  = 32'h0000_1a2c;
	localparam logic [DATA_W-1:0] PPCR_VAL = 32'h0000_8a40;
	localparam logic [DATA_W-1:0] FI0R_VAL = 32'hf0e1_d2c3;
	localparam logic [DATA_W-1:0] JUMP_VAL = 32'h0002_3c10;

	logic iCLOCK;
	logic inRESET;
	logic except_jump;
	logic [DATA_W-1:0] jump_addr;
	logic except_ret;
	logic irq_req;
	logic [IRQ_NUM_W-1:0] irq_num;
	logic [DATA_W-1:0] irq_fi0r;
	logic interrupt_lock;
	logic [DATA_W-1:0] sysreg_spr;
	logic [DATA_W-1:0] sysreg_tidr;
	logic [DATA_W-1:0] sysreg_tisr;
	logic [DATA_W-1:0] sysreg_psr;
	logic [DATA_W-1:0] sysreg_ppsr;
	logic [DATA_W-1:0] sysreg_pcr;
	logic [DATA_W-1:0] sysreg_ppcr;
	logic [DATA_W-1:0] sysreg_idtr;
	logic ldst_busy;
	logic ldst_valid;
	logic [DATA_W-1:0] ldst_rdata;

	wire register_lock;
	wire pipeline_stop;
	wire refresh;
	wire pc_set;
	wire [DATA_W-1:0] pc;
	wire ppcr_set;
	wire [DATA_W-1:0] ppcr_out;
	wire fi0r_set;
	wire [DATA_W-1:0] fi0r;
	wire set_irq_mode;
	wire clr_irq_mode;
	wire cache_flush;
	wire tlb_flush;
	wire spr_write;
	wire [DATA_W-1:0] spr_value;
	wire irq_ack;
	wire ldst_req;
	wire ldst_rw;
	wire [DATA_W-1:0] ldst_addr;
	wire [DATA_W-1:0] ldst_wdata;

	int cycle = 0;
	int check_errors = 0;
	int prop_errors = 0;
	int addr_errors = 0;
	int err_mark;
	int tests_run = 0;
	int tests_passed = 0;
	string cur_test = "none";
	logic busy_on;

	// Pulse, stall and access logs per sequence
	int refresh_cyc[$];
	int ppcr_cyc[$];
	logic [DATA_W-1:0] ppcr_val[$];
	int pcset_cyc[$];
	logic [DATA_W-1:0] pcset_val[$];
	int ack_cyc[$];
	logic [DATA_W-1:0] ack_fi0r[$];
	int clr_cyc[$];
	int flush_cyc[$];
	int stop_cyc[$];
	int lock_cyc[$];
	logic [DATA_W-1:0] sprw_val[$];
	logic [DATA_W-1:0] acc_addr[$];
	logic acc_rw[$];
	logic [DATA_W-1:0] acc_wdata[$];

	exception_manager UUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2.0) iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) cycle <= cycle + 1;

	// Memory contents from the rotated full address
	function automatic logic [DATA_W-1:0] mem_word(input logic [DATA_W-1:0] addr);
		return {addr[11:0], addr[31:12]} ^ 32'h6b2d_91e7;
	endfunction

	function automatic logic [DATA_W-1:0] psr_word(input logic [PSR_MODE_W-1:0] mode,
		input logic irq_en);
		logic [DATA_W-1:0] w;
		w = '0;
		w[PSR_MODE_LSB +: PSR_MODE_W] = mode;
		w[PSR_IRQ_EN_BIT] = irq_en;
		return w;
	endfunction

	function automatic int total_errors();
		return check_errors + prop_errors + addr_errors;
	endfunction

	// Load/store memory answering after 1 to 4 cycles
	initial begin : memory_model
		logic mem_pending;
		logic mem_rw;
		int mem_wait;
		logic [DATA_W-1:0] mem_addr;
		mem_pending = 1'b0;
		mem_rw      = 1'b0;
		mem_wait    = 0;
		mem_addr    = '0;
		ldst_busy   = 1'b0;
		ldst_valid  = 1'b0;
		ldst_rdata  = '0;
		forever begin
			@(negedge iCLOCK);
			if (inRESET && ldst_req) begin
				acc_addr.push_back(ldst_addr);
				acc_rw.push_back(ldst_rw);
				acc_wdata.push_back(ldst_wdata);
				mem_addr    = ldst_addr;
				mem_rw      = ldst_rw;
				mem_wait    = int'($urandom_range(4, 1)) - 1;
				mem_pending = 1'b1;
			end
			@(posedge iCLOCK);
			#(DRIVE_DELAY);
			ldst_valid = 1'b0;
			if (mem_pending) begin
				if (mem_wait == 0) begin
					ldst_valid  = 1'b1;
					ldst_rdata  = mem_rw ? '0 : mem_word(mem_addr);
					mem_pending = 1'b0;
				end else begin
					mem_wait = mem_wait - 1;
				end
			end
			ldst_busy = busy_on && ($urandom_range(2, 0) == 0);
		end
	end

	always @(negedge iCLOCK) begin
		if (inRESET) begin
			if (refresh) refresh_cyc.push_back(cycle);
			if (cache_flush) flush_cyc.push_back(cycle);
			if (clr_irq_mode) clr_cyc.push_back(cycle);
			if (pipeline_stop) stop_cyc.push_back(cycle);
			if (register_lock) lock_cyc.push_back(cycle);
			if (spr_write) sprw_val.push_back(spr_value);
			if (ppcr_set) begin
				ppcr_cyc.push_back(cycle);
				ppcr_val.push_back(ppcr_out);
			end
			if (pc_set) begin
				pcset_cyc.push_back(cycle);
				pcset_val.push_back(pc);
			end
			if (irq_ack) begin
				ack_cyc.push_back(cycle);
				ack_fi0r.push_back(fi0r);
			end
		end
	end

	// Address held from op_start until the request leaves
	logic track_addr = 1'b0;
	logic [DATA_W-1:0] start_addr;
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			if (UUT.op_start) begin
				start_addr = ldst_addr;
				track_addr = 1'b1;
			end else if (track_addr) begin
				assert (ldst_addr === start_addr) else begin
					addr_errors++;
					$display("request address moved before the request in test %s", cur_test);
				end
				if (ldst_req) track_addr = 1'b0;
			end
		end
	end

	req_not_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req |-> !ldst_busy) else begin
		prop_errors++;
		$display("request raised while ldst_busy high in test %s", cur_test);
	end
	flush_pair: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		cache_flush == tlb_flush) else begin
		prop_errors++;
		$display("cache_flush and tlb_flush differ in test %s", cur_test);
	end
	entry_end: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(irq_ack || fi0r_set) |-> (irq_ack && fi0r_set && pc_set)) else begin
		prop_errors++;
		$display("irq_ack, pc_set and fi0r_set not raised together in test %s", cur_test);
	end
	entry_start: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ppcr_set == set_irq_mode) else begin
		prop_errors++;
		$display("ppcr_set and set_irq_mode differ in test %s", cur_test);
	end

	task automatic step();
		@(posedge iCLOCK);
		#(DRIVE_DELAY);
	endtask

	task automatic check_word(input string what, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		assert (act === exp) else begin
			check_errors++;
			$display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_int(input string what, input int exp, input int act);
		assert (act == exp) else begin
			check_errors++;
			$display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	// Exactly one pulse in the given cycle
	task automatic check_pulse(input string what, input int cyc_q[$], input int exp_cyc);
		check_int({what, " count"}, 1, cyc_q.size());
		if (cyc_q.size() > 0) check_int({what, " cycle"}, exp_cyc, cyc_q[0]);
	endtask

	// One unbroken run of cycles from first to last
	task automatic check_window(input string what, input int cyc_q[$], input int first,
		input int last);
		check_int({what, " cycles"}, last - first + 1, cyc_q.size());
		if (cyc_q.size() > 0) begin
			check_int({what, " first cycle"}, first, cyc_q[0]);
			check_int({what, " last cycle"}, last, cyc_q[cyc_q.size() - 1]);
		end
	endtask

	task automatic check_access(input int idx, input logic [DATA_W-1:0] addr, input logic rw);
		if (idx < acc_addr.size()) begin
			check_word($sformatf("access %0d address", idx), addr, acc_addr[idx]);
			check_word($sformatf("access %0d write", idx), {31'b0, rw}, {31'b0, acc_rw[idx]});
			if (rw) check_word($sformatf("access %0d data", idx), SPR_VAL, acc_wdata[idx]);
		end
	endtask

	task automatic check_quiet();
		check_word("pulse outputs", 32'd0, {21'd0, refresh, pc_set, ppcr_set, fi0r_set,
			set_irq_mode, clr_irq_mode, cache_flush, tlb_flush, spr_write, irq_ack, ldst_req});
	endtask

	task automatic clear_logs();
		refresh_cyc.delete();
		ppcr_cyc.delete();
		ppcr_val.delete();
		pcset_cyc.delete();
		pcset_val.delete();
		ack_cyc.delete();
		ack_fi0r.delete();
		clr_cyc.delete();
		flush_cyc.delete();
		stop_cyc.delete();
		lock_cyc.delete();
		sprw_val.delete();
		acc_addr.delete();
		acc_rw.delete();
		acc_wdata.delete();
	endtask

	function automatic bit marker_seen(input int kind);
		if (kind == EV_JUMP) return pcset_cyc.size() > 0;
		if (kind == EV_IRQ) return ack_cyc.size() > 0;
		return clr_cyc.size() > 0;
	endfunction

	// Event held for one cycle while the DUT is idle
	task automatic fire_event(input int kind, output int accept_cyc);
		step();
		accept_cyc = cycle;
		case (kind)
			EV_JUMP: except_jump = 1'b1;
			EV_IRQ:  irq_req = 1'b1;
			default: except_ret = 1'b1;
		endcase
		step();
		except_jump = 1'b0;
		irq_req     = 1'b0;
		except_ret  = 1'b0;
	endtask

	task automatic wait_marker(input int kind);
		int waited;
		waited = 0;
		while (!marker_seen(kind) && waited < MARKER_TIMEOUT) begin
			@(posedge iCLOCK);
			waited++;
		end
		if (!marker_seen(kind)) begin
			check_errors++;
			$display("test %s timed out waiting for the end of the sequence", cur_test);
		end
		repeat (4) step();
	endtask

	task automatic run_jump();
		int n;
		clear_logs();
		fire_event(EV_JUMP, n);
		wait_marker(EV_JUMP);
		check_pulse("refresh", refresh_cyc, n + 1);
		check_pulse("pc_set", pcset_cyc, n + 2);
		if (pcset_val.size() > 0) check_word("jump pc", JUMP_VAL, pcset_val[0]);
		check_int("memory accesses", 0, acc_addr.size());
		check_int("irq_ack count", 0, ack_cyc.size());
		check_window("pipeline_stop", stop_cyc, n + 1, n + 1);
		check_window("register_lock", lock_cyc, n + 1, n + 2);
	endtask

	task automatic run_irq_entry(input bit user);
		int n;
		logic [DATA_W-1:0] vec_addr;
		logic [DATA_W-1:0] tss_base;
		vec_addr = IDTR_VAL + 32'(IRQ_NUMBER) * 32'd8 + 32'd4;
		tss_base = TISR_VAL + TIDR_VAL * 32'd256;
		clear_logs();
		step();
		sysreg_psr = psr_word(user ? MODE_USER : MODE_KERNEL, 1'b1);
		fire_event(EV_IRQ, n);
		wait_marker(EV_IRQ);
		check_pulse("refresh", refresh_cyc, n + 1);
		check_pulse("ppcr_set", ppcr_cyc, n + 1);
		if (ppcr_val.size() > 0) check_word("ppcr_out", PCR_VAL, ppcr_val[0]);
		check_int("irq_ack count", 1, ack_cyc.size());
		if (ack_cyc.size() > 0) begin
			check_pulse("pc_set", pcset_cyc, ack_cyc[0]);
			check_window("pipeline_stop", stop_cyc, n, ack_cyc[0] - 1);
			check_window("register_lock", lock_cyc, n, ack_cyc[0]);
		end
		if (pcset_val.size() > 0) check_word("vector pc", mem_word(vec_addr), pcset_val[0]);
		if (ack_fi0r.size() > 0) check_word("fi0r", FI0R_VAL, ack_fi0r[0]);
		check_int("memory accesses", user ? 3 : 1, acc_addr.size());
		check_access(0, vec_addr, 1'b0);
		if (user) begin
			check_access(1, tss_base + 32'd12, 1'b1);
			check_access(2, tss_base + 32'd8, 1'b0);
		end
		check_int("spr_write count", user ? 1 : 0, sprw_val.size());
		if (user && sprw_val.size() > 0)
			check_word("spr_value", mem_word(tss_base + 32'd8), sprw_val[0]);
		check_int("clr_irq_mode count", 0, clr_cyc.size());
	endtask

	task automatic run_return(input bit user);
		int n;
		logic [DATA_W-1:0] tss_base;
		tss_base = TISR_VAL + TIDR_VAL * 32'd256;
		clear_logs();
		step();
		sysreg_psr  = psr_word(MODE_KERNEL, 1'b0);
		sysreg_ppsr = psr_word(user ? MODE_USER : MODE_KERNEL, 1'b1);
		fire_event(EV_RET, n);
		wait_marker(EV_RET);
		check_pulse("refresh", refresh_cyc, n + 1);
		check_pulse("cache_flush", flush_cyc, n + 1);
		check_int("clr_irq_mode count", 1, clr_cyc.size());
		if (clr_cyc.size() > 0) begin
			check_pulse("pc_set", pcset_cyc, clr_cyc[0]);
			check_window("pipeline_stop", stop_cyc, n + 1, clr_cyc[0] - 1);
			check_window("register_lock", lock_cyc, n + 1, clr_cyc[0]);
		end
		if (pcset_val.size() > 0) check_word("return pc", PPCR_VAL, pcset_val[0]);
		check_int("memory accesses", user ? 2 : 0, acc_addr.size());
		if (user) begin
			check_access(0, tss_base + 32'd8, 1'b1);
			check_access(1, tss_base + 32'd12, 1'b0);
		end
		check_int("spr_write count", user ? 1 : 0, sprw_val.size());
		if (user && sprw_val.size() > 0)
			check_word("spr_value", mem_word(tss_base + 32'd12), sprw_val[0]);
		check_int("irq_ack count", 0, ack_cyc.size());
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_mark = total_errors();
	endtask

	task automatic end_test();
		tests_run++;
		if (total_errors() == err_mark) begin
			tests_passed++;
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: FAILED, %0d errors", cur_test, total_errors() - err_mark);
		end
	endtask

	initial begin : watchdog
		#(CLK_PERIOD * TEST_COUNT * CYCLES_PER_TEST);
		$display("watchdog expired after %0d cycles, run stopped",
			TEST_COUNT * CYCLES_PER_TEST);
		$display("Test failures found");
		$finish;
	end

	initial begin : main
		void'($urandom(SEED));
		inRESET        = 1'b0;
		busy_on        = 1'b0;
		except_jump    = 1'b0;
		except_ret     = 1'b0;
		irq_req        = 1'b0;
		interrupt_lock = 1'b0;
		jump_addr      = JUMP_VAL;
		irq_num        = IRQ_NUMBER;
		irq_fi0r       = FI0R_VAL;
		sysreg_spr     = SPR_VAL;
		sysreg_tidr    = TIDR_VAL;
		sysreg_tisr    = TISR_VAL;
		sysreg_psr     = '0;
		sysreg_ppsr    = '0;
		sysreg_pcr     = PCR_VAL;
		sysreg_ppcr    = PPCR_VAL;
		sysreg_idtr    = IDTR_VAL;

		begin_test("reset");
		repeat (RESET_CYCLES) begin
			@(negedge iCLOCK);
			check_quiet();
		end
		step();
		inRESET = 1'b1;
		repeat (4) begin
			@(negedge iCLOCK);
			check_quiet();
		end
		end_test();

		begin_test("jump");
		run_jump();
		end_test();

		begin_test("irq_kernel");
		clear_logs();
		step();
		sysreg_psr     = psr_word(MODE_KERNEL, 1'b1);
		interrupt_lock = 1'b1;
		irq_req        = 1'b1;
		repeat (10) step();
		irq_req        = 1'b0;
		interrupt_lock = 1'b0;
		repeat (3) step();
		check_int("entries under lock", 0, refresh_cyc.size());
		check_int("accesses under lock", 0, acc_addr.size());
		check_int("stalls under lock", 0, stop_cyc.size());
		run_irq_entry(1'b0);
		end_test();

		begin_test("irq_user");
		run_irq_entry(1'b1);
		end_test();

		begin_test("irq_return");
		run_return(1'b1);
		run_return(1'b0);
		end_test();

		// Same sequences with a stalling memory port
		begin_test("backpressure");
		@(negedge iCLOCK);
		busy_on = 1'b1;
		run_irq_entry(1'b0);
		run_irq_entry(1'b1);
		run_return(1'b1);
		run_return(1'b0);
		@(negedge iCLOCK);
		busy_on = 1'b0;
		end_test();

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_passed, tests_run - tests_passed, total_errors());
		if (tests_passed == tests_run && total_errors() == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
